//--- design/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
  input  logic                clock,
  input  logic                reset,
  input  logic                instret,
  output csr_pkg::counters_t  counters
);

  logic [63:0] cycle_count;
  logic [63:0] cycle_next;
  logic [63:0] instret_count;
  logic [63:0] instret_next;

  // cycle counter runs every clock once out of reset.
  always_comb begin
    cycle_next = cycle_count + 64'd1;
  end

  always_comb begin
    instret_next = instret_count;
    if (instret) begin
      instret_next = instret_count + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= 64'd0;
    end else begin
      cycle_count <= cycle_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      instret_count <= 64'd0;
    end else begin
      instret_count <= instret_next;
    end
  end

  always_comb begin
    counters.cycle   = cycle_count;
    counters.instret = instret_count;
  end

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  csr_pkg::csr_req_t   req,
  input  logic [31:0]         pc,
  input  csr_pkg::counters_t  counters,
  output csr_pkg::wb_t        wb,
  output csr_pkg::redirect_t  redirect,
  output logic                illegal
);

  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;

  logic [31:0] rdata;
  logic [31:0] wvalue;
  logic        illegal_csr;
  logic        csr_ok;
  logic        csr_we;

  // read mux. counters and id registers are visible but not writable.
  always_comb begin
    rdata       = 32'd0;
    illegal_csr = 1'b0;
    case (req.addr)
      csr_pkg::MSTATUS:   rdata = mstatus;
      csr_pkg::MTVEC:     rdata = mtvec;
      csr_pkg::MEPC:      rdata = mepc;
      csr_pkg::MCAUSE:    rdata = mcause;
      csr_pkg::MCYCLE:    rdata = counters.cycle[31:0];
      csr_pkg::MINSTRET:  rdata = counters.instret[31:0];
      csr_pkg::MCYCLEH:   rdata = counters.cycle[63:32];
      csr_pkg::MINSTRETH: rdata = counters.instret[63:32];
      csr_pkg::MVENDORID: rdata = csr_pkg::MVENDORID_VALUE;
      csr_pkg::MARCHID:   rdata = csr_pkg::MARCHID_VALUE;
      default:            illegal_csr = 1'b1;
    endcase
  end

  // read-modify-write value against the current contents.
  always_comb begin
    case (req.op)
      csr_pkg::WRITE: wvalue = req.wdata;
      csr_pkg::SET:   wvalue = rdata | req.wdata;
      csr_pkg::CLEAR: wvalue = rdata & ~req.wdata;
      default:        wvalue = rdata;
    endcase
  end

  assign csr_ok = req.enable && !illegal_csr;
  assign csr_we = csr_ok && (req.op != csr_pkg::READ);

  // ecall wins over mret, and mret over any csr write.
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= csr_pkg::MSTATUS_RESET;
      mtvec   <= 32'd0;
      mepc    <= 32'd0;
      mcause  <= 32'd0;
    end else if (req.ecall) begin
      mstatus <= csr_pkg::MSTATUS_RESET;
      mepc    <= pc;
      mcause  <= csr_pkg::ECALL_CAUSE;
    end else if (!req.mret && csr_we) begin
      case (req.addr)
        csr_pkg::MSTATUS: mstatus <= wvalue;
        csr_pkg::MTVEC:   mtvec <= wvalue;
        csr_pkg::MEPC:    mepc <= wvalue;
        csr_pkg::MCAUSE:  mcause <= wvalue;
        // counter and id writes are dropped.
        default: ;
      endcase
    end
  end

  // write-back carries the old value; x0 destination suppresses the write.
  always_comb begin
    wb       = '0;
    wb.rd    = req.rd;
    wb.write = csr_ok && (req.rd != 5'd0);
    if (csr_ok) begin
      wb.data = rdata;
    end
  end

  always_comb begin
    redirect       = '0;
    redirect.valid = req.ecall || req.mret;
    if (req.ecall) begin
      redirect.pc = mtvec;
    end else if (req.mret) begin
      redirect.pc = mepc;
    end
  end

  assign illegal = (req.enable && illegal_csr) || req.bad_instr;

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

  // major opcode shared by every SYSTEM instruction.
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // funct3 encodings within the SYSTEM opcode.
  localparam logic [2:0] FUNCT3_PRIV   = 3'b000;
  localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
  localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
  localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
  localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
  localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

  // funct12 selects the privileged instruction when funct3 is zero.
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  // mpp = machine, written on reset and on every trap.
  localparam logic [31:0] MSTATUS_RESET = 32'h0000_1800;

  // environment call from machine mode.
  localparam logic [31:0] ECALL_CAUSE = 32'd11;

  localparam logic [31:0] MVENDORID_VALUE = 32'h0000_0000;
  localparam logic [31:0] MARCHID_VALUE   = 32'h0000_0019;

  typedef enum logic [11:0] {
    MSTATUS   = 12'h300,
    MTVEC     = 12'h305,
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    MCYCLE    = 12'hB00,
    MINSTRET  = 12'hB02,
    MCYCLEH   = 12'hB80,
    MINSTRETH = 12'hB82,
    MVENDORID = 12'hF11,
    MARCHID   = 12'hF12
  } csr_addr_e;

  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1,
    SET   = 2'd2,
    CLEAR = 2'd3
  } csr_op_e;

  // one decoded SYSTEM instruction.
  typedef struct packed {
    logic        enable;
    csr_op_e     op;
    csr_addr_e   addr;
    logic [31:0] wdata;
    logic [4:0]  rd;
    logic        ecall;
    logic        mret;
    logic        bad_instr;
  } csr_req_t;

  typedef struct packed {
    logic        write;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [63:0] cycle;
    logic [63:0] instret;
  } counters_t;

endpackage

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                valid,
  input  logic [31:0]         instr,
  input  logic [31:0]         pc,
  input  logic [31:0]         rs1_data,
  input  logic                instret,
  output csr_pkg::wb_t        wb,
  output csr_pkg::redirect_t  redirect,
  output logic                illegal
);

  csr_pkg::csr_req_t  req;
  csr_pkg::counters_t counters;

  // combinational decode of the strobed instruction.
  system_decoder u_decoder (
    .valid    (valid),
    .instr    (instr),
    .rs1_data (rs1_data),
    .req      (req)
  );

  csr_counters u_counters (
    .clock    (clock),
    .reset    (reset),
    .instret  (instret),
    .counters (counters)
  );

  csr_file u_csr_file (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .pc       (pc),
    .counters (counters),
    .wb       (wb),
    .redirect (redirect),
    .illegal  (illegal)
  );

endmodule

//--- design/system_decoder.sv
`timescale 1ns/1ps

module system_decoder (
  input  logic               valid,
  input  logic [31:0]        instr,
  input  logic [31:0]        rs1_data,
  output csr_pkg::csr_req_t  req
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic [4:0]  rs1_field;
  logic [4:0]  rd_field;
  logic        is_system;
  logic        is_csr;
  logic        is_ecall;
  logic        is_mret;
  logic        is_bad;
  csr_pkg::csr_op_e base_op;

  assign opcode    = instr[6:0];
  assign rd_field  = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1_field = instr[19:15];
  assign funct12   = instr[31:20];

  assign is_system = valid && (opcode == csr_pkg::OPCODE_SYSTEM);

  // classify the SYSTEM word by funct3, then funct12 for the privileged group.
  always_comb begin
    is_csr   = 1'b0;
    is_ecall = 1'b0;
    is_mret  = 1'b0;
    is_bad   = 1'b0;
    if (is_system) begin
      case (funct3)
        csr_pkg::FUNCT3_PRIV: begin
          if (funct12 == csr_pkg::FUNCT12_ECALL) begin
            is_ecall = 1'b1;
          end else if (funct12 == csr_pkg::FUNCT12_MRET) begin
            is_mret = 1'b1;
          end else begin
            is_bad = 1'b1;
          end
        end
        csr_pkg::FUNCT3_CSRRW, csr_pkg::FUNCT3_CSRRS, csr_pkg::FUNCT3_CSRRC,
        csr_pkg::FUNCT3_CSRRWI, csr_pkg::FUNCT3_CSRRSI, csr_pkg::FUNCT3_CSRRCI: begin
          is_csr = 1'b1;
        end
        default: begin
          is_bad = 1'b1;
        end
      endcase
    end
  end

  // low two funct3 bits give the operation for both register and immediate forms.
  always_comb begin
    case (funct3[1:0])
      2'b01:   base_op = csr_pkg::WRITE;
      2'b10:   base_op = csr_pkg::SET;
      2'b11:   base_op = csr_pkg::CLEAR;
      default: base_op = csr_pkg::READ;
    endcase
  end

  always_comb begin
    req           = '0;
    req.enable    = is_csr;
    req.ecall     = is_ecall;
    req.mret      = is_mret;
    req.bad_instr = is_bad;
    if (is_csr) begin
      req.addr = csr_pkg::csr_addr_e'(funct12);
      req.rd   = rd_field;
      // funct3[2] selects the zero-extended uimm form.
      req.wdata = funct3[2] ? {27'b0, rs1_field} : rs1_data;
      // set or clear with x0 / zero uimm must not write.
      if (base_op != csr_pkg::WRITE && rs1_field == 5'd0) begin
        req.op = csr_pkg::READ;
      end else begin
        req.op = base_op;
      end
    end
  end

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clock = 1'b0;
    forever begin
      #HALF_PERIOD clock = ~clock;
    end
  end

  // reset spans three rising edges, then drops on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- dv/csr_tests.svh
`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic test_reset_values();
  idle(1);
  expect_read(csr_pkg::MSTATUS, 32'h0000_1800);
  expect_read(csr_pkg::MTVEC, 32'd0);
  expect_read(csr_pkg::MEPC, 32'd0);
  expect_read(csr_pkg::MCAUSE, 32'd0);
  idle(1);
endtask

task automatic test_write_set_clear();
  logic [31:0] value;
  logic [4:0]  uimm;
  value = rand_bits(32);
  run_csr(csr_pkg::FUNCT3_CSRRW, csr_pkg::MTVEC, rand_reg(), rand_reg(), value, m_mtvec);
  m_mtvec = value;
  uimm = rand_reg();
  run_csr(csr_pkg::FUNCT3_CSRRWI, csr_pkg::MEPC, uimm, rand_reg(), 32'hDEAD_BEEF, m_mepc);
  m_mepc = {27'd0, uimm};
  expect_read(csr_pkg::MTVEC, m_mtvec);
  expect_read(csr_pkg::MEPC, m_mepc);
  // back-to-back strobes, each seeing the previous write.
  repeat (3) begin
    value = rand_bits(32);
    run_csr(csr_pkg::FUNCT3_CSRRS, csr_pkg::MTVEC, rand_reg(), rand_reg(), value, m_mtvec);
    m_mtvec = m_mtvec | value;
    value = rand_bits(32);
    run_csr(csr_pkg::FUNCT3_CSRRC, csr_pkg::MEPC, rand_reg(), rand_reg(), value, m_mepc);
    m_mepc = m_mepc & ~value;
    value = rand_bits(32);
    run_csr(csr_pkg::FUNCT3_CSRRC, csr_pkg::MTVEC, rand_reg(), rand_reg(), value, m_mtvec);
    m_mtvec = m_mtvec & ~value;
    value = rand_bits(32);
    run_csr(csr_pkg::FUNCT3_CSRRS, csr_pkg::MEPC, rand_reg(), rand_reg(), value, m_mepc);
    m_mepc = m_mepc | value;
    expect_read(csr_pkg::MTVEC, m_mtvec);
    expect_read(csr_pkg::MEPC, m_mepc);
  end
  uimm = rand_reg();
  run_csr(csr_pkg::FUNCT3_CSRRSI, csr_pkg::MTVEC, uimm, rand_reg(), 32'd0, m_mtvec);
  m_mtvec = m_mtvec | {27'd0, uimm};
  uimm = rand_reg();
  run_csr(csr_pkg::FUNCT3_CSRRCI, csr_pkg::MEPC, uimm, rand_reg(), 32'd0, m_mepc);
  m_mepc = m_mepc & ~{27'd0, uimm};
  // x0 source turns set and clear into a plain read.
  run_csr(csr_pkg::FUNCT3_CSRRS, csr_pkg::MTVEC, 5'd0, rand_reg(), 32'hFFFF_FFFF, m_mtvec);
  run_csr(csr_pkg::FUNCT3_CSRRC, csr_pkg::MEPC, 5'd0, rand_reg(), 32'hFFFF_FFFF, m_mepc);
  run_csr(csr_pkg::FUNCT3_CSRRCI, csr_pkg::MTVEC, 5'd0, rand_reg(), 32'd0, m_mtvec);
  expect_read(csr_pkg::MTVEC, m_mtvec);
  expect_read(csr_pkg::MEPC, m_mepc);
  value = rand_bits(32);
  run_csr(csr_pkg::FUNCT3_CSRRW, csr_pkg::MEPC, rand_reg(), 5'd0, value, m_mepc);
  m_mepc = value;
  expect_read(csr_pkg::MEPC, m_mepc);
  idle(1);
endtask

task automatic test_counters();
  logic [31:0] k;
  logic [31:0] n;
  logic [31:0] first;
  k = 32'd2 + rand_bits(3);
  strobe(csr_word(csr_pkg::FUNCT3_CSRRS, csr_pkg::MCYCLE, 5'd0, rand_reg()), 32'd0, 32'd0);
  check_bit("wb.write", 1'b1, wb.write);
  first = wb.data;
  idle(k - 32'd1);
  expect_read(csr_pkg::MCYCLE, first + k);
  strobe(csr_word(csr_pkg::FUNCT3_CSRRS, csr_pkg::MINSTRET, 5'd0, rand_reg()), 32'd0, 32'd0);
  check_bit("wb.write", 1'b1, wb.write);
  first = wb.data;
  n = 32'd1 + rand_bits(4);
  retire(n);
  expect_read(csr_pkg::MINSTRET, first + n);
  expect_read(csr_pkg::MCYCLEH, 32'd0);
  expect_read(csr_pkg::MINSTRETH, 32'd0);
  idle(1);
endtask

task automatic test_ecall_mret();
  logic [31:0] value;
  logic [31:0] trap_pc;
  value = rand_bits(32);
  run_csr(csr_pkg::FUNCT3_CSRRW, csr_pkg::MSTATUS, rand_reg(), rand_reg(), value, m_mstatus);
  m_mstatus = value;
  value = rand_bits(32) & 32'hFFFF_FFFC;
  run_csr(csr_pkg::FUNCT3_CSRRW, csr_pkg::MTVEC, rand_reg(), 5'd0, value, m_mtvec);
  m_mtvec = value;
  trap_pc = rand_bits(32) & 32'hFFFF_FFFC;
  strobe(csr_word(3'b000, 12'h000, 5'd0, 5'd0), 32'd0, trap_pc);
  check_redirect("redirect", make_redirect(1'b1, m_mtvec), redirect);
  check_bit("wb.write", 1'b0, wb.write);
  check_bit("illegal", 1'b0, illegal);
  m_mepc    = trap_pc;
  m_mcause  = 32'd11;
  m_mstatus = 32'h0000_1800;
  idle(1);
  expect_read(csr_pkg::MEPC, m_mepc);
  expect_read(csr_pkg::MCAUSE, m_mcause);
  expect_read(csr_pkg::MSTATUS, m_mstatus);
  strobe(csr_word(3'b000, 12'h302, 5'd0, 5'd0), 32'd0, rand_bits(32));
  check_redirect("redirect", make_redirect(1'b1, m_mepc), redirect);
  check_bit("wb.write", 1'b0, wb.write);
  check_bit("illegal", 1'b0, illegal);
  idle(1);
endtask

task automatic test_illegal();
  logic [31:0] value;
  logic [4:0]  rd;
  value = rand_bits(32);
  rd = rand_reg();
  strobe(csr_word(csr_pkg::FUNCT3_CSRRW, 12'h7C0, rand_reg(), rd), value, 32'd0);
  check_bit("illegal", 1'b1, illegal);
  check_bit("wb.write", 1'b0, wb.write);
  check_redirect("redirect", make_redirect(1'b0, 32'd0), redirect);
  expect_read(csr_pkg::MSTATUS, m_mstatus);
  expect_read(csr_pkg::MTVEC, m_mtvec);
  expect_read(csr_pkg::MEPC, m_mepc);
  expect_read(csr_pkg::MCAUSE, m_mcause);
  // wfi is not supported, so its funct12 is unknown here.
  strobe(csr_word(3'b000, 12'h105, 5'd0, 5'd0), 32'd0, 32'd0);
  check_bit("illegal", 1'b1, illegal);
  check_bit("wb.write", 1'b0, wb.write);
  check_redirect("redirect", make_redirect(1'b0, 32'd0), redirect);
  strobe(csr_word(3'b100, csr_pkg::MSTATUS, rand_reg(), rand_reg()), value, 32'd0);
  check_bit("illegal", 1'b1, illegal);
  check_bit("wb.write", 1'b0, wb.write);
  expect_read(csr_pkg::MSTATUS, m_mstatus);
  expect_read(csr_pkg::MVENDORID, csr_pkg::MVENDORID_VALUE);
  expect_read(csr_pkg::MARCHID, csr_pkg::MARCHID_VALUE);
  run_csr(csr_pkg::FUNCT3_CSRRW, csr_pkg::MVENDORID, rand_reg(), rd, value,
          csr_pkg::MVENDORID_VALUE);
  run_csr(csr_pkg::FUNCT3_CSRRS, csr_pkg::MARCHID, rand_reg(), rd, value,
          csr_pkg::MARCHID_VALUE);
  expect_read(csr_pkg::MVENDORID, csr_pkg::MVENDORID_VALUE);
  expect_read(csr_pkg::MARCHID, csr_pkg::MARCHID_VALUE);
  idle(1);
endtask

`endif

//--- dv/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int CLOCK_PERIOD = 20;
  localparam int SAMPLE_DELAY = 5;
  // cycle budget of each test in the order they run.
  localparam int TEST_CYCLES = 8 + 40 + 40 + 12 + 20;
  localparam int MARGIN_CYCLES = 100;
  localparam logic [15:0] LFSR_SEED = 16'd2651;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic               clock;
  logic               reset;
  logic               valid;
  logic [31:0]        instr;
  logic [31:0]        pc;
  logic [31:0]        rs1_data;
  logic               instret;
  csr_pkg::wb_t       wb;
  csr_pkg::redirect_t redirect;
  logic               illegal;

  logic [15:0] lfsr_state;

  // reference copies of the writable registers.
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  csr_unit u_csr_unit (
    .clock    (clock),
    .reset    (reset),
    .valid    (valid),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .instret  (instret),
    .wb       (wb),
    .redirect (redirect),
    .illegal  (illegal)
  );

  function automatic logic step_lfsr();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], step_lfsr()};
    end
    return value;
  endfunction

  // nonzero register number that also serves as a nonzero uimm.
  function automatic logic [4:0] rand_reg();
    logic [31:0] bits;
    bits = rand_bits(5);
    if (bits[4:0] == 5'd0) begin
      bits[0] = 1'b1;
    end
    return bits[4:0];
  endfunction

  function automatic logic [31:0] csr_word(input logic [2:0] funct3, input logic [11:0] addr,
                                           input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, funct3, rd, csr_pkg::OPCODE_SYSTEM};
  endfunction

  function automatic csr_pkg::wb_t make_wb(input logic write, input logic [4:0] rd,
                                           input logic [31:0] data);
    csr_pkg::wb_t value;
    value.write = write;
    value.rd    = rd;
    value.data  = data;
    return value;
  endfunction

  function automatic csr_pkg::redirect_t make_redirect(input logic v, input logic [31:0] target);
    csr_pkg::redirect_t value;
    value.valid = v;
    value.pc    = target;
    return value;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    $display("ERRORS FOUND");
    $fatal(1, "mismatch on %s", name);
  endtask

  // rd and data only matter when a write-back is expected.
  task automatic check_wb(input string name, input csr_pkg::wb_t exp, input csr_pkg::wb_t act);
    logic bad;
    bad = (act.write !== exp.write);
    if (exp.write) begin
      bad = bad || (act.rd !== exp.rd) || (act.data !== exp.data);
    end
    if (bad) begin
      report_mismatch(name, {26'd0, exp}, {26'd0, act});
    end
  endtask

  task automatic check_redirect(input string name, input csr_pkg::redirect_t exp,
                                input csr_pkg::redirect_t act);
    if (act !== exp) begin
      report_mismatch(name, {31'd0, exp}, {31'd0, act});
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_mismatch(name, {63'd0, exp}, {63'd0, act});
    end
  endtask

  task automatic strobe(input logic [31:0] word, input logic [31:0] src,
                        input logic [31:0] at_pc);
    @(negedge clock);
    valid    = 1'b1;
    instr    = word;
    rs1_data = src;
    pc       = at_pc;
    instret  = 1'b0;
    #SAMPLE_DELAY;
  endtask

  // quiet cycles in which every output must read as zero.
  task automatic idle(input logic [31:0] cycles);
    repeat (cycles) begin
      @(negedge clock);
      valid    = 1'b0;
      instr    = 32'd0;
      rs1_data = 32'd0;
      pc       = 32'd0;
      instret  = 1'b0;
      #SAMPLE_DELAY;
      check_wb("wb", make_wb(1'b0, 5'd0, 32'd0), wb);
      check_redirect("redirect", make_redirect(1'b0, 32'd0), redirect);
      check_bit("illegal", 1'b0, illegal);
    end
  endtask

  task automatic retire(input logic [31:0] count);
    repeat (count) begin
      @(negedge clock);
      valid   = 1'b0;
      instret = 1'b1;
    end
  endtask

  // pure read through csrrs with x0 as source.
  task automatic expect_read(input logic [11:0] addr, input logic [31:0] value);
    logic [4:0] rd;
    rd = rand_reg();
    strobe(csr_word(csr_pkg::FUNCT3_CSRRS, addr, 5'd0, rd), 32'hFFFF_FFFF, 32'd0);
    check_wb("wb", make_wb(1'b1, rd, value), wb);
    check_bit("illegal", 1'b0, illegal);
    check_redirect("redirect", make_redirect(1'b0, 32'd0), redirect);
  endtask

  task automatic run_csr(input logic [2:0] funct3, input logic [11:0] addr,
                         input logic [4:0] rs1, input logic [4:0] rd,
                         input logic [31:0] src, input logic [31:0] old);
    strobe(csr_word(funct3, addr, rs1, rd), src, 32'd0);
    check_wb("wb", make_wb(rd != 5'd0, rd, old), wb);
    check_bit("illegal", 1'b0, illegal);
  endtask

  `include "csr_tests.svh"

  initial begin
    valid       = 1'b0;
    instr       = 32'd0;
    pc          = 32'd0;
    rs1_data    = 32'd0;
    instret     = 1'b0;
    lfsr_state  = LFSR_SEED;
    m_mstatus   = 32'h0000_1800;
    m_mtvec     = 32'd0;
    m_mepc      = 32'd0;
    m_mcause    = 32'd0;
    wait (reset == 1'b0);
    @(posedge clock);
    test_reset_values();
    test_write_set_clear();
    test_counters();
    test_ecall_mret();
    test_illegal();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the csr_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
BIN=csr_unit_sim

verilator --binary --timing -f src.f --top-module csr_unit_tb \
  -Mdir "$OBJ_DIR" -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi

//--- src.f
+incdir+dv
design/csr_pkg.sv
design/system_decoder.sv
design/csr_counters.sv
design/csr_file.sv
design/csr_unit.sv
dv/clock_gen.sv
dv/csr_unit_tb.sv
